// ==== Makefile ====
# Verilator build of the hpdmc testbench, rebuilt when a listed source changes
SRCS := $(shell cat hpdmc_top.f)

.PHONY: run clean

run: obj_dir/Vtb_hpdmc
	@out="$$(./obj_dir/Vtb_hpdmc)"; echo "$$out"; echo "$$out" | grep -q '^STATUS: PASS$$'

obj_dir/Vtb_hpdmc: hpdmc_top.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_hpdmc -f hpdmc_top.f

clean:
	rm -rf obj_dir

// ==== common/hpdmc_bus_pkg.sv ====
// ################################################
// bus and pin structs, widths come from the cfg package
// dq is 32 bits wide, two beats make one 64-bit word
// ################################################

package hpdmc_bus_pkg;
	import hpdmc_cfg_pkg::*;

	// single-word access from one master
	typedef struct packed {
		logic [addr_bits-1:0] addr;	// {bank, row, col}
		logic                 we;
		logic [63:0]          wdata;
		logic [7:0]           wmask;	// 1 = byte gets written
	} mem_req_t;

	// sdram command pins, all active low controls
	typedef struct packed {
		logic                 cs_n;
		logic                 ras_n;
		logic                 cas_n;
		logic                 we_n;
		logic [bank_bits-1:0] ba;
		logic [row_bits-1:0]  a;
	} sdram_cmd_t;

	typedef enum logic [2:0] {nop, activate, read, write, precharge} cmd_kind_t;

	// ddr data pins, split out since there is no tristate here
	typedef struct packed {
		logic [31:0] dq_o;
		logic        dq_oe;
		logic [3:0]  dm;	// 1 = byte masked
		logic [3:0]  dqs_o;
		logic        dqs_oe;
	} ddr_pins_t;

endpackage

// ==== common/hpdmc_cfg_pkg.sv ====
// ################################################
// word-addressed geometry, one 64-bit word per access
// all timings in sys_clk cycles, no refresh timing
// ################################################

package hpdmc_cfg_pkg;

	// ################################################
	// geometry
	// ################################################
	localparam int bank_bits = 2;
	localparam int row_bits  = 11;
	localparam int col_bits  = 8;
	localparam int addr_bits = bank_bits + row_bits + col_bits;	// 21-bit word address

	// ################################################
	// timing
	// ################################################
	localparam int t_rcd       = 2;	// activate to read/write
	localparam int cas_latency = 2;	// read to first beat
	localparam int t_wr        = 2;	// write data to precharge
	localparam int t_rp        = 2;	// precharge to idle

	localparam int num_masters = 2;
	localparam int id_bits     = $clog2(num_masters);	// master index width

endpackage

// ==== ctl/hpdmc_datactl.sv ====
// ################################################
// dq direction and read capture timing from the issued command
// cmd_kind must be aligned with the command on the pins
// ################################################

module hpdmc_datactl
	import hpdmc_cfg_pkg::*;
	import hpdmc_bus_pkg::*;
(
	input  logic      sys_clk,
	input  logic      reset,
	input  cmd_kind_t cmd_kind,
	output logic      direction,	// drive window, write cycle
	output logic      direction_r,	// one later, data cycle
	output logic      rd_capture	// captured word valid
);

	logic [cas_latency:0] rd_sr;	// read in flight, one bit per cycle

	assign direction  = (cmd_kind == write);
	assign rd_capture = rd_sr[cas_latency];	// cas_latency + 1 after read

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			direction_r <= 1'b0;
			rd_sr       <= '0;
		end else begin
			direction_r <= direction;
			rd_sr       <= {rd_sr[cas_latency-1:0], cmd_kind == read};
		end
	end

	// no dq drive while a read is still on its way back
	a_no_overlap: assert property (@(posedge sys_clk) disable iff (reset)
		(direction || direction_r) |-> (rd_sr == '0));

endmodule

// ==== ctl/hpdmc_mgmt.sv ====
// ################################################
// closed page only: activate, read or write, precharge
// one access at a time, fixed delays from the cfg package
// ################################################

module hpdmc_mgmt
	import hpdmc_cfg_pkg::*;
	import hpdmc_bus_pkg::*;
(
	input  logic               sys_clk,
	input  logic               reset,
	input  logic               gnt_valid,
	input  logic [id_bits-1:0] gnt_id,
	input  mem_req_t           gnt_req,
	input  logic               rd_capture,	// di valid this cycle
	input  logic [63:0]        di,
	output logic               busy,
	output logic               done,
	output logic [id_bits-1:0] done_id,
	output logic [63:0]        rdata,
	output sdram_cmd_t         cmd,
	output cmd_kind_t          cmd_kind,
	output logic [63:0]        wdata,	// to ddrio
	output logic [7:0]         mo	// dm, inverted wmask
);

	typedef enum logic [2:0] {s_idle, s_rcd, s_wr, s_rd, s_rp} state_t;

	state_t               state;
	logic [2:0]           cnt;	// delay counter, counts down to 0
	mem_req_t             cur;	// access in flight
	logic [id_bits-1:0]   cur_id;
	logic [bank_bits-1:0] bank;
	logic [row_bits-1:0]  row;
	logic [col_bits-1:0]  col;
	logic                 start;
	logic                 finish;

	assign {bank, row, col} = cur.addr;
	assign busy    = (state != s_idle);
	assign start   = gnt_valid && (state == s_idle);
	assign finish  = (state == s_wr && cnt == '0) || (state == s_rd && rd_capture);
	assign done_id = cur_id;
	assign wdata   = cur.wdata;
	assign mo      = ~cur.wmask;

	// ################################################
	// sequencer
	// ################################################
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			state    <= s_idle;
			cnt      <= '0;
			cmd_kind <= nop;
			done     <= 1'b0;
		end else begin
			cmd_kind <= nop;	// one command per cycle at most
			done     <= finish;	// ack goes out with the precharge
			case (state)
			s_idle: if (start) begin
				cmd_kind <= activate;
				cnt      <= 3'(t_rcd - 1);
				state    <= s_rcd;
			end
			s_rcd: if (cnt != '0) begin
				cnt <= cnt - 3'd1;
			end else if (cur.we) begin
				cmd_kind <= write;
				cnt      <= 3'(t_wr);	// one extra for the data cycle
				state    <= s_wr;
			end else begin
				cmd_kind <= read;
				state    <= s_rd;
			end
			s_wr, s_rd: if (finish) begin
				cmd_kind <= precharge;
				cnt      <= 3'(t_rp - 1);
				state    <= s_rp;
			end else if (cnt != '0) begin
				cnt <= cnt - 3'd1;
			end
			s_rp: if (cnt != '0) cnt <= cnt - 3'd1;
				else state <= s_idle;
			default: state <= s_idle;
			endcase
		end
	end

	// payload
	always_ff @(posedge sys_clk) begin
		if (start) begin
			cur    <= gnt_req;
			cur_id <= gnt_id;
		end
		if (state == s_rd && rd_capture)
			rdata <= di;
	end

	// pin encoding, deselect when idle
	always_comb begin
		cmd = '{1'b1, 1'b1, 1'b1, 1'b1, '0, '0};
		case (cmd_kind)
		activate:  cmd = '{1'b0, 1'b0, 1'b1, 1'b1, bank, row};
		read:      cmd = '{1'b0, 1'b1, 1'b0, 1'b1, bank, row_bits'(col)};	// a10 low, no auto precharge
		write:     cmd = '{1'b0, 1'b1, 1'b0, 1'b0, bank, row_bits'(col)};
		precharge: cmd = '{1'b0, 1'b0, 1'b1, 1'b0, bank, '0};	// this bank only
		default:   ;
		endcase
	end

	// nothing but nops inside the t_rcd window after an activate
	for (genvar k = 1; k < t_rcd; k++) begin : g_rcd
		a_rcd: assert property (@(posedge sys_clk) disable iff (reset)
			cmd_kind != nop |-> $past(cmd_kind, k) != activate);
	end

endmodule

// ==== ddrio/hpdmc_ddrio.sv ====
// ################################################
// behavioral ddr registers, falling sys_clk edge for the second beat
// dqs runs off sys_clk, no idelay, no tristate buffers
// ################################################

module hpdmc_ddrio
	import hpdmc_bus_pkg::*;
(
	input  logic        sys_clk,
	input  logic        direction_r,	// drive enable
	input  logic [7:0]  mo,	// dm per byte
	input  logic [63:0] wdata,
	input  logic [31:0] dq_i,
	output logic [63:0] di,
	output ddr_pins_t   pins
);

	logic [31:0] dq_rise;	// high half, first beat
	logic [31:0] dq_fall;	// low half, second beat
	logic [3:0]  dm_rise;
	logic [3:0]  dm_fall;
	logic [31:0] in_rise;
	logic [31:0] in_fall;

	// ################################################
	// outputs
	// ################################################
	always_ff @(posedge sys_clk) begin
		dq_rise <= wdata[63:32];
		dm_rise <= mo[7:4];
	end

	always_ff @(negedge sys_clk) begin
		dq_fall <= wdata[31:0];
		dm_fall <= mo[3:0];
	end

	// clock selects the beat, like an oddr
	always_comb begin
		pins.dq_o   = sys_clk ? dq_rise : dq_fall;
		pins.dm     = sys_clk ? dm_rise : dm_fall;
		pins.dqs_o  = {4{sys_clk}};	// high on rise, low on fall
		pins.dq_oe  = direction_r;
		pins.dqs_oe = direction_r;
	end

	// ################################################
	// inputs
	// ################################################
	always_ff @(posedge sys_clk) in_rise <= dq_i;
	always_ff @(negedge sys_clk) in_fall <= dq_i;

	assign di = {in_fall, in_rise};	// rising beat lands low

endmodule

// ==== hpdmc_top.f ====
common/hpdmc_cfg_pkg.sv
common/hpdmc_bus_pkg.sv
logic/hpdmc_arbiter.sv
ctl/hpdmc_mgmt.sv
ctl/hpdmc_datactl.sv
ddrio/hpdmc_ddrio.sv
logic/hpdmc_top.sv
tb/sdram_model.sv
tb/tb_hpdmc.sv

// ==== logic/hpdmc_arbiter.sv ====
// ################################################
// round robin over strobe levels, grants only while mgmt idle
// masters hold stb and req stable until their ack pulse
// ################################################

module hpdmc_arbiter
	import hpdmc_cfg_pkg::*;
	import hpdmc_bus_pkg::*;
#(
	parameter type payload_t = mem_req_t
) (
	input  logic                         sys_clk,
	input  logic                         reset,
	input  logic     [num_masters-1:0]   stb,
	input  payload_t [num_masters-1:0]   req,
	input  logic                         busy,	// sequencer running
	input  logic                         done,	// access finished
	input  logic     [id_bits-1:0]       done_id,
	output logic                         gnt_valid,
	output logic     [id_bits-1:0]       gnt_id,
	output payload_t                     gnt_req,
	output logic     [num_masters-1:0]   ack
);

	logic [num_masters-1:0] outstanding;	// granted, not yet acked
	logic [num_masters-1:0] pending;
	logic [id_bits-1:0]     last;	// last master served
	logic                   any;

	assign pending = stb & ~outstanding;

	// walk from the farthest master to the nearest so the nearest wins
	always_comb begin
		gnt_id = last;
		any    = 1'b0;
		for (int i = num_masters; i >= 1; i--) begin
			if (pending[(int'(last) + i) % num_masters]) begin
				gnt_id = id_bits'((int'(last) + i) % num_masters);
				any    = 1'b1;
			end
		end
	end

	assign gnt_valid = any && !busy;
	assign gnt_req   = req[gnt_id];
	assign ack       = done ? (num_masters'(1) << done_id) : '0;	// route done to owner

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			outstanding <= '0;
			last        <= id_bits'(num_masters - 1);	// master 0 goes first
		end else begin
			if (gnt_valid) begin
				outstanding[gnt_id] <= 1'b1;
				last                <= gnt_id;
			end
			if (done)
				outstanding[done_id] <= 1'b0;
		end
	end

	// a granted sequencer leaves idle
	a_gnt_idle: assert property (@(posedge sys_clk) disable iff (reset)
		gnt_valid |=> busy);
	// ack only to a master that was granted
	a_ack_owner: assert property (@(posedge sys_clk) disable iff (reset)
		(ack & ~outstanding) == '0);

endmodule

// ==== logic/hpdmc_top.sv ====
// ################################################
// two masters, one sdram, closed page single-word accesses
// dq and dqs leave as separate out, in and enable signals
// ################################################

module hpdmc_top
	import hpdmc_cfg_pkg::*;
	import hpdmc_bus_pkg::*;
(
	input  logic                         sys_clk,
	input  logic                         reset,
	input  logic     [num_masters-1:0]   stb,
	input  mem_req_t [num_masters-1:0]   req,
	input  logic     [31:0]              dq_i,
	output logic     [num_masters-1:0]   ack,
	output logic     [63:0]              rdata,	// shared by all masters
	output sdram_cmd_t                   cmd,
	output ddr_pins_t                    pins
);

	logic               gnt_valid;
	logic [id_bits-1:0] gnt_id;
	mem_req_t           gnt_req;
	logic               busy;
	logic               done;
	logic [id_bits-1:0] done_id;
	cmd_kind_t          cmd_kind;
	logic [63:0]        wdata;
	logic [7:0]         mo;
	logic [63:0]        di;
	logic               direction_r;
	logic               rd_capture;

	hpdmc_arbiter #(.payload_t(mem_req_t)) u_arbiter (
		.sys_clk, .reset, .stb, .req, .busy, .done, .done_id,
		.gnt_valid, .gnt_id, .gnt_req, .ack
	);

	hpdmc_mgmt u_mgmt (
		.sys_clk, .reset, .gnt_valid, .gnt_id, .gnt_req, .rd_capture, .di,
		.busy, .done, .done_id, .rdata, .cmd, .cmd_kind, .wdata, .mo
	);

	hpdmc_datactl u_datactl (
		.sys_clk, .reset, .cmd_kind, .direction(), .direction_r, .rd_capture
	);

	hpdmc_ddrio u_ddrio (
		.sys_clk, .direction_r, .mo, .wdata, .dq_i, .di, .pins
	);

endmodule

// ==== tb/sdram_model.sv ====
// ################################################
// behavioral ddr sdram, one 64-bit word per column
// one access in flight, no refresh, no timing checks
// ################################################

module sdram_model
	import hpdmc_cfg_pkg::*;
	import hpdmc_bus_pkg::*;
(
	input  logic        sys_clk,
	input  sdram_cmd_t  cmd,
	input  ddr_pins_t   pins,
	output logic [31:0] dq_i
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [row_bits-1:0]  open_row [1 << bank_bits];	// per bank, set by activate
	logic [63:0]          mem [logic [addr_bits-1:0]];	// sparse storage
	logic [addr_bits-1:0] key;
	logic [63:0]          word;

	initial dq_i = '0;

	// commands sampled mid-cycle where they are stable
	always @(negedge sys_clk) begin
		if (!cmd.cs_n) begin
			key  = {cmd.ba, open_row[cmd.ba], cmd.a[col_bits-1:0]};
			word = mem.exists(key) ? mem[key] : '0;	// never written reads as zero
			case ({cmd.ras_n, cmd.cas_n, cmd.we_n})
			3'b011: open_row[cmd.ba] = cmd.a;	// activate
			3'b100: begin	// write, beats come in the next cycle
				@(posedge sys_clk);
				#5;	// high half rides the high clock phase
				for (int b = 0; b < 4; b++)
					if (pins.dq_oe && pins.dqs_oe && pins.dqs_o[b] && !pins.dm[b])
						word[32 + 8*b +: 8] = pins.dq_o[8*b +: 8];	// lane strobe high
				@(negedge sys_clk);
				#5;	// low half on the low phase
				for (int b = 0; b < 4; b++)
					if (pins.dq_oe && pins.dqs_oe && !pins.dqs_o[b] && !pins.dm[b])
						word[8*b +: 8] = pins.dq_o[8*b +: 8];	// lane strobe low
				mem[key] = word;
			end
			3'b101: begin	// read
				// low half around the rising capture edge, high half around the falling one
				repeat (cas_latency) @(negedge sys_clk);
				#5 dq_i = word[31:0];
				@(posedge sys_clk);
				#5 dq_i = word[63:32];
				@(negedge sys_clk);
				#5 dq_i = '0;
			end
			default: ;	// precharge needs no action here
			endcase
		end
	end

endmodule

// ==== tb/tb_hpdmc.sv ====
// ################################################
// two masters against the sdram model, shadow memory reference
// outputs checked at the falling edge, inputs driven 2 ns after rise
// ################################################

module tb_hpdmc
	import hpdmc_cfg_pkg::*;
	import hpdmc_bus_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	logic                          sys_clk = 1'b0;
	logic                          reset;
	logic     [num_masters-1:0]    stb;
	mem_req_t [num_masters-1:0]    req;
	logic     [31:0]               dq_i;
	logic     [num_masters-1:0]    ack;
	logic     [63:0]               rdata;
	sdram_cmd_t                    cmd;
	ddr_pins_t                     pins;

	logic [31:0]        lfsr = 32'hdcfb33e9;
	logic [63:0]        shadow [logic [addr_bits-1:0]];	// expected sdram contents
	string              test_name = "reset";
	logic               alternating = 1'b0;	// ack order checked
	logic               first_ack;
	logic [id_bits-1:0] last_id;
	int                 issued = 0;
	int                 acks_seen = 0;

	always #10 sys_clk = ~sys_clk;	// 20 ns period

	hpdmc_top u_dut (
		.sys_clk, .reset, .stb, .req, .dq_i, .ack, .rdata, .cmd, .pins
	);

	sdram_model u_sdram (
		.sys_clk, .cmd, .pins, .dq_i
	);

	// ################################################
	// reference and helpers
	// ################################################
	// galois lfsr, one step per bit taken
	function automatic logic [63:0] next_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[62:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// writes merge enabled bytes, returns the word after the access
	function automatic logic [63:0] reference(input mem_req_t r);
		logic [63:0] word;
		word = shadow.exists(r.addr) ? shadow[r.addr] : '0;
		if (r.we) begin
			for (int b = 0; b < 8; b++)
				if (r.wmask[b])
					word[8*b +: 8] = r.wdata[8*b +: 8];
			shadow[r.addr] = word;
		end
		return word;
	endfunction

	function automatic mem_req_t make_req(input logic [addr_bits-1:0] addr, input logic we,
			input logic [63:0] wdata, input logic [7:0] wmask);
		mem_req_t r;
		r.addr  = addr;
		r.we    = we;
		r.wdata = wdata;
		r.wmask = wmask;
		return r;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_equal(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected)
			abort_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic check_idle(input string when);
		check_equal({when, " ack"}, 64'(0), 64'(ack));
		check_equal({when, " cmd"}, 64'(4'hf),
			64'({cmd.cs_n, cmd.ras_n, cmd.cas_n, cmd.we_n}));	// nop, deselected
		check_equal({when, " dq_oe"}, 64'(0), 64'(pins.dq_oe));
		check_equal({when, " dqs_oe"}, 64'(0), 64'(pins.dqs_oe));
	endtask

	// two reset edges, ends in the drive slot
	task automatic apply_reset();
		reset = 1'b1;
		stb   = '0;
		@(posedge sys_clk);
		@(negedge sys_clk);
		check_idle("in reset");
		@(posedge sys_clk);
		#2 reset = 1'b0;
		repeat (2) begin
			@(negedge sys_clk);
			check_idle("after reset");
			@(posedge sys_clk);
		end
		#2;
	endtask

	// hold strobe until ack, called in the drive slot
	task automatic access(input int m, input mem_req_t r);
		int n;
		stb[m] = 1'b1;
		req[m] = r;
		issued++;
		n = 0;
		do begin
			@(negedge sys_clk);
			n++;
		end while (!ack[m] && n < 100);
		if (!ack[m])
			abort_run($sformatf("master %0d got no ack within 100 cycles", m));
		@(posedge sys_clk);
		#2 stb[m] = 1'b0;	// a following access raises it again right away
	endtask

	task automatic paired_traffic(input int m);
		mem_req_t r;
		for (int i = 0; i < 3; i++) begin
			r = make_req({bank_bits'(m), row_bits'(7), col_bits'(i)}, 1'b1,
				{32'(m), 32'(i)} ^ 64'h5555_aaaa_3333_cccc, 8'hff);
			access(m, r);
			r.we = 1'b0;
			access(m, r);
		end
	endtask

	task automatic random_traffic(input int m, input int count);
		mem_req_t   r;
		logic [3:0] a;
		for (int i = 0; i < count; i++) begin
			a       = 4'(next_bits(4));
			r.addr  = {bank_bits'(a[3]), row_bits'(a[2]), col_bits'(a[1:0])};	// 16 words
			r.we    = 1'(next_bits(1));
			r.wdata = next_bits(64);
			r.wmask = 8'(next_bits(8));
			access(m, r);
			repeat (int'(next_bits(2))) begin	// idle gap
				@(posedge sys_clk);
				#2;
			end
		end
	endtask

	// ################################################
	// comparing process
	// ################################################
	always @(negedge sys_clk) begin : compare
		logic [id_bits-1:0] id;
		logic [63:0]        expected;
		if (reset) begin
			first_ack = 1'b1;
		end else if (ack != '0) begin
			id       = ack[1];	// two masters
			expected = reference(req[id]);
			if (!req[id].we)
				check_equal({test_name, " rdata"}, expected, rdata);
			if (alternating)
				check_equal({test_name, " ack order"},
					64'(first_ack ? id_bits'(0) : id_bits'(last_id + 1'b1)), 64'(id));
			first_ack = 1'b0;
			last_id   = id;
			acks_seen++;
		end
	end

	// ################################################
	// stimulus
	// ################################################
	initial begin
		logic [addr_bits-1:0] addr_a;
		addr_a = {bank_bits'(1), row_bits'(5), col_bits'(3)};
		reset  = 1'b1;
		stb    = '0;
		req    = '0;
		apply_reset();

		test_name = "write read";
		access(0, make_req(addr_a, 1'b1, 64'h0123_4567_89ab_cdef, 8'hff));
		access(0, make_req(addr_a, 1'b0, '0, '0));

		test_name = "partial write";
		access(0, make_req(addr_a, 1'b1, 64'hfeed_f00d_dead_beef, 8'h5a));
		access(0, make_req(addr_a, 1'b0, '0, '0));

		apply_reset();	// priority back to master 0
		test_name   = "alternating";
		alternating = 1'b1;
		fork
			paired_traffic(0);
			paired_traffic(1);
		join
		alternating = 1'b0;

		test_name = "random";
		fork
			random_traffic(0, 100);
			random_traffic(1, 100);
		join

		check_equal("ack count", 64'(issued), 64'(acks_seen));
		$display("STATUS: PASS");
		$finish;
	end

endmodule
